// File: src/neighborPkg.sv
package neighborPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes of the neighbor-list memory.
    localparam int NumPorts = 4;
    localparam int NumBanks = 4;
    localparam int BankWords = 16;
    localparam int FifoDepth = 4;
    localparam int BankLatency = 2;

    localparam int AddrWidth = 6;
    localparam int BankSelWidth = 2;
    localparam int WordAddrWidth = 4;
    localparam int DataWidth = 16;
    localparam int TagWidth = 2;

    localparam int FifoPtrWidth = $clog2(FifoDepth);
    localparam int FifoCountWidth = $clog2(FifoDepth + 1);
    localparam int BusyCntWidth = $clog2(BankLatency + 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [AddrWidth-1:0] addrT;          // Bank in the top bits, word below.
    typedef logic [BankSelWidth-1:0] bankSelT;
    typedef logic [WordAddrWidth-1:0] wordAddrT;
    typedef logic [DataWidth-1:0] dataT;
    typedef logic [TagWidth-1:0] tagT;            // Requester port number.

    typedef enum logic [1:0] {idle, route, stall, issue} dispStateT;

endpackage

// File: src/requestArbiter.sv
`timescale 1ns/100ps

module requestArbiter (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic [neighborPkg::NumPorts-1:0]              reqValid,
    input  logic [neighborPkg::NumPorts-1:0]              reqWrite,
    input  neighborPkg::addrT [neighborPkg::NumPorts-1:0] reqAddr,
    input  neighborPkg::dataT [neighborPkg::NumPorts-1:0] reqData,
    input  logic                                          full,
    output logic [neighborPkg::NumPorts-1:0]              reqAccept,
    output logic                                          push,
    output logic                                          pushWrite,
    output neighborPkg::addrT                             pushAddr,
    output neighborPkg::dataT                             pushData,
    output neighborPkg::tagT                              pushTag
);

    logic [neighborPkg::NumPorts-1:0] eligible;
    neighborPkg::tagT lastWinner;
    neighborPkg::tagT winner;
    logic found;

    // A port whose accept is showing still holds its old request this cycle.
    assign eligible = reqValid & ~reqAccept;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Round-robin search, starting one past the last winner.
    always_comb begin
        neighborPkg::tagT cand;
        found = 1'b0;
        winner = lastWinner;
        cand = lastWinner;
        for (int offset = 1; offset <= neighborPkg::NumPorts; offset++) begin
            cand = neighborPkg::tagT'((int'(lastWinner) + offset) % neighborPkg::NumPorts);
            if (!found && eligible[cand]) begin
                found = 1'b1;
                winner = cand;
            end
        end
        if (full) begin
            found = 1'b0;  // No grant while the FIFO cannot take the entry.
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            reqAccept <= '0;
            push <= 1'b0;
            lastWinner <= neighborPkg::tagT'(neighborPkg::NumPorts - 1);  // Port 0 goes first.
        end else begin
            push <= found;
            reqAccept <= '0;
            if (found) begin
                reqAccept[winner] <= 1'b1;
                lastWinner <= winner;
            end
        end
    end

    // Payload of the granted request, tagged with its port number.
    always_ff @(posedge clk) begin
        if (found) begin
            pushWrite <= reqWrite[winner];
            pushAddr <= reqAddr[winner];
            pushData <= reqData[winner];
            pushTag <= winner;
        end
    end

endmodule

// File: src/requestFifo.sv
`timescale 1ns/100ps

module requestFifo (
    input  logic              clk,
    input  logic              reset,
    input  logic              push,
    input  logic              pushWrite,
    input  neighborPkg::addrT pushAddr,
    input  neighborPkg::dataT pushData,
    input  neighborPkg::tagT  pushTag,
    input  logic              pop,
    output logic              popWrite,
    output neighborPkg::addrT popAddr,
    output neighborPkg::dataT popData,
    output neighborPkg::tagT  popTag,
    output logic              empty,
    output logic              full
);

    logic              memWrite [neighborPkg::FifoDepth];
    neighborPkg::addrT memAddr [neighborPkg::FifoDepth];
    neighborPkg::dataT memData [neighborPkg::FifoDepth];
    neighborPkg::tagT  memTag [neighborPkg::FifoDepth];

    logic [neighborPkg::FifoPtrWidth-1:0] wrPtr;
    logic [neighborPkg::FifoPtrWidth-1:0] rdPtr;
    logic [neighborPkg::FifoCountWidth-1:0] count;

    assign empty = (count == 0);
    // The arbiter's push is one cycle behind its grant, so the last free slot counts as taken.
    assign full = (count == neighborPkg::FifoDepth) ||
                  ((count == neighborPkg::FifoDepth - 1) && push);

    always_ff @(posedge clk) begin
        if (!reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == neighborPkg::FifoDepth - 1) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == neighborPkg::FifoDepth - 1) ? '0 : rdPtr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            memWrite[wrPtr] <= pushWrite;
            memAddr[wrPtr] <= pushAddr;
            memData[wrPtr] <= pushData;
            memTag[wrPtr] <= pushTag;
        end
        if (pop) begin
            popWrite <= memWrite[rdPtr];  // Valid in the cycle after the pop.
            popAddr <= memAddr[rdPtr];
            popData <= memData[rdPtr];
            popTag <= memTag[rdPtr];
        end
    end

endmodule

// File: src/neighborMemCntl.sv
`timescale 1ns/100ps

module neighborMemCntl (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             empty,
    input  logic                             popWrite,
    input  neighborPkg::addrT                popAddr,
    input  neighborPkg::dataT                popData,
    input  neighborPkg::tagT                 popTag,
    input  logic [neighborPkg::NumBanks-1:0] busy,
    output logic                             pop,
    output logic [neighborPkg::NumBanks-1:0] issue,
    output logic                             issueWrite,
    output neighborPkg::wordAddrT            issueWord,
    output neighborPkg::dataT                issueData,
    output neighborPkg::tagT                 issueTag
);

    neighborPkg::dispStateT state;
    neighborPkg::dispStateT nextState;

    neighborPkg::bankSelT popBank;
    neighborPkg::bankSelT bankQ;
    logic writeQ;
    neighborPkg::wordAddrT wordQ;
    neighborPkg::dataT dataQ;
    neighborPkg::tagT tagQ;

    // Bank from the top address bits of the entry the FIFO presents.
    assign popBank = popAddr[neighborPkg::AddrWidth-1 -: neighborPkg::BankSelWidth];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Dispatch FSM.
    always_comb begin
        nextState = state;
        case (state)
            neighborPkg::idle: begin
                if (!empty) begin
                    nextState = neighborPkg::route;
                end
            end
            neighborPkg::route: begin
                if (busy[popBank]) begin
                    nextState = neighborPkg::stall;
                end else begin
                    nextState = neighborPkg::issue;
                end
            end
            neighborPkg::stall: begin
                if (!busy[bankQ]) begin
                    nextState = neighborPkg::issue;  // Wait ends once the bank is free.
                end
            end
            neighborPkg::issue: begin
                nextState = neighborPkg::idle;
            end
            default: begin
                nextState = neighborPkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= neighborPkg::idle;
        end else begin
            state <= nextState;
        end
    end

    // The popped request is held from route until its issue.
    always_ff @(posedge clk) begin
        if (state == neighborPkg::route) begin
            bankQ <= popBank;
            writeQ <= popWrite;
            wordQ <= popAddr[neighborPkg::WordAddrWidth-1:0];
            dataQ <= popData;
            tagQ <= popTag;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Strobes and the shared issue bus.
    always_comb begin
        pop = (state == neighborPkg::idle) && !empty;
        issue = '0;
        if (state == neighborPkg::issue) begin
            issue[bankQ] = 1'b1;  // Only the decoded bank sees the pulse.
        end
    end

    assign issueWrite = writeQ;
    assign issueWord = wordQ;
    assign issueData = dataQ;
    assign issueTag = tagQ;

endmodule

// File: src/neighborBankCntl.sv
`timescale 1ns/100ps

module neighborBankCntl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue,
    input  logic                  issueWrite,
    input  neighborPkg::wordAddrT issueWord,
    input  neighborPkg::dataT     issueData,
    input  neighborPkg::tagT      issueTag,
    output logic                  busy,
    output logic                  rspValid,
    output neighborPkg::tagT      rspTag,
    output neighborPkg::dataT     rspData
);

    neighborPkg::dataT mem [neighborPkg::BankWords];

    logic [neighborPkg::BusyCntWidth-1:0] busyCnt;
    logic readPending;
    neighborPkg::dataT readData;
    neighborPkg::tagT readTag;

    assign busy = (busyCnt != 0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control: busy window and read pipeline valids.
    always_ff @(posedge clk) begin
        if (!reset) begin
            busyCnt <= '0;
            readPending <= 1'b0;
            rspValid <= 1'b0;
        end else begin
            if (issue) begin
                busyCnt <= neighborPkg::BusyCntWidth'(neighborPkg::BankLatency);
            end else if (busyCnt != 0) begin
                busyCnt <= busyCnt - 1'b1;
            end
            readPending <= issue && !issueWrite;
            rspValid <= readPending;  // Two cycles after the issue.
        end
    end

    // Storage and the read data path.
    always_ff @(posedge clk) begin
        if (issue && issueWrite) begin
            mem[issueWord] <= issueData;
        end
        if (issue && !issueWrite) begin
            readData <= mem[issueWord];
            readTag <= issueTag;
        end
        if (readPending) begin
            rspData <= readData;
            rspTag <= readTag;
        end
    end

endmodule

// File: src/neighborMemTop.sv
`timescale 1ns/100ps

module neighborMemTop (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic [neighborPkg::NumPorts-1:0]              reqValid,
    input  logic [neighborPkg::NumPorts-1:0]              reqWrite,
    input  neighborPkg::addrT [neighborPkg::NumPorts-1:0] reqAddr,
    input  neighborPkg::dataT [neighborPkg::NumPorts-1:0] reqData,
    output logic [neighborPkg::NumPorts-1:0]              reqAccept,
    output logic [neighborPkg::NumBanks-1:0]              rspValid,
    output neighborPkg::tagT [neighborPkg::NumBanks-1:0]  rspTag,
    output neighborPkg::dataT [neighborPkg::NumBanks-1:0] rspData
);

    logic push;
    logic pushWrite;
    neighborPkg::addrT pushAddr;
    neighborPkg::dataT pushData;
    neighborPkg::tagT pushTag;
    logic full;
    logic empty;
    logic pop;
    logic popWrite;
    neighborPkg::addrT popAddr;
    neighborPkg::dataT popData;
    neighborPkg::tagT popTag;
    logic [neighborPkg::NumBanks-1:0] busy;
    logic [neighborPkg::NumBanks-1:0] issue;
    logic issueWrite;
    neighborPkg::wordAddrT issueWord;
    neighborPkg::dataT issueData;
    neighborPkg::tagT issueTag;

    requestArbiter arb0 (
        .clk(clk), .reset(reset),
        .reqValid(reqValid), .reqWrite(reqWrite), .reqAddr(reqAddr), .reqData(reqData),
        .full(full), .reqAccept(reqAccept),
        .push(push), .pushWrite(pushWrite), .pushAddr(pushAddr),
        .pushData(pushData), .pushTag(pushTag)
    );

    requestFifo fifo0 (
        .clk(clk), .reset(reset),
        .push(push), .pushWrite(pushWrite), .pushAddr(pushAddr),
        .pushData(pushData), .pushTag(pushTag), .pop(pop),
        .popWrite(popWrite), .popAddr(popAddr), .popData(popData), .popTag(popTag),
        .empty(empty), .full(full)
    );

    neighborMemCntl cntl0 (
        .clk(clk), .reset(reset), .empty(empty),
        .popWrite(popWrite), .popAddr(popAddr), .popData(popData), .popTag(popTag),
        .busy(busy), .pop(pop), .issue(issue), .issueWrite(issueWrite),
        .issueWord(issueWord), .issueData(issueData), .issueTag(issueTag)
    );

    // One controller per bank on the shared issue bus.
    for (genvar b = 0; b < neighborPkg::NumBanks; b++) begin : genBank
        neighborBankCntl bank (
            .clk(clk), .reset(reset), .issue(issue[b]), .issueWrite(issueWrite),
            .issueWord(issueWord), .issueData(issueData), .issueTag(issueTag),
            .busy(busy[b]), .rspValid(rspValid[b]), .rspTag(rspTag[b]), .rspData(rspData[b])
        );
    end

endmodule

// File: bench/neighborMem_props.sv
`timescale 1ns/100ps

module neighborMemCntlProps (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [neighborPkg::NumBanks-1:0] issue,
    input  logic [neighborPkg::NumBanks-1:0] busy,
    input  logic                             pop,
    input  logic                             empty
);

    logic failed = 1'b0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    issueOneHot: assert property (@(posedge clk) disable iff (!reset) $onehot0(issue))
        else begin
            failed = 1'b1;
            $error("More than one bank issued in the same cycle.");
        end

    issueNotBusy: assert property (@(posedge clk) disable iff (!reset) (issue & busy) == '0)
        else begin
            failed = 1'b1;
            $error("Issue sent to a bank that is still busy.");
        end

    popNotEmpty: assert property (@(posedge clk) disable iff (!reset) pop |-> !empty)
        else begin
            failed = 1'b1;
            $error("Pop while the FIFO is empty.");
        end

endmodule

module requestArbiterProps (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [neighborPkg::NumPorts-1:0] reqAccept
);

    logic failed = 1'b0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    acceptOneHot: assert property (@(posedge clk) disable iff (!reset) $onehot0(reqAccept))
        else begin
            failed = 1'b1;
            $error("More than one port accepted in the same cycle.");
        end

endmodule

bind neighborMemCntl neighborMemCntlProps cntlProps (
    .clk(clk), .reset(reset), .issue(issue), .busy(busy),
    .pop(pop), .empty(empty)
);

bind requestArbiter requestArbiterProps arbProps (
    .clk(clk), .reset(reset), .reqAccept(reqAccept)
);

// File: bench/neighborMemTb.sv
`timescale 1ns/100ps

module neighborMemTb;

    logic clk;
    logic reset;
    logic [neighborPkg::NumPorts-1:0] reqValid;
    logic [neighborPkg::NumPorts-1:0] reqWrite;
    neighborPkg::addrT [neighborPkg::NumPorts-1:0] reqAddr;
    neighborPkg::dataT [neighborPkg::NumPorts-1:0] reqData;
    logic [neighborPkg::NumPorts-1:0] reqAccept;
    logic [neighborPkg::NumBanks-1:0] rspValid;
    neighborPkg::tagT [neighborPkg::NumBanks-1:0] rspTag;
    neighborPkg::dataT [neighborPkg::NumBanks-1:0] rspData;

    int tracePhase[$];
    int tracePort[$];
    int traceWrite[$];
    int traceAddr[$];
    int traceData[$];
    int traceExp[$];
    int numLines = 0;
    int maxPhase = 0;

    int pendPort[$];  // Reads sent and not yet answered, oldest first.
    int pendLine[$];
    int cycles = 0;
    int cycleLimit = 0;

    neighborMemTop dut0 (
        .clk(clk), .reset(reset),
        .reqValid(reqValid), .reqWrite(reqWrite), .reqAddr(reqAddr), .reqData(reqData),
        .reqAccept(reqAccept), .rspValid(rspValid), .rspTag(rspTag), .rspData(rspData)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped.");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            reportFailure($sformatf("[ERROR] %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // True once a bound assertion on the dispatcher or the arbiter has fired.
    function automatic logic assertionFailed();
        return dut0.cntl0.cntlProps.failed || dut0.arb0.arbProps.failed;
    endfunction

    task automatic loadTrace();
        int fd;
        int cnt;
        int ph;
        int pt;
        int wr;
        int ad;
        int da;
        int ex;
        string line;
        fd = $fopen("bench/neighborTrace.txt", "r");
        if (fd == 0) begin
            reportFailure("Could not open the trace file bench/neighborTrace.txt.");
        end
        while (!$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            if (cnt > 0 && $sscanf(line, "%d %d %d %h %h %h", ph, pt, wr, ad, da, ex) == 6) begin
                tracePhase.push_back(ph);
                tracePort.push_back(pt);
                traceWrite.push_back(wr);
                traceAddr.push_back(ad);
                traceData.push_back(da);
                traceExp.push_back(ex);
                if (ph > maxPhase) maxPhase = ph;
            end
        end
        $fclose(fd);
        numLines = tracePhase.size();
        if (numLines == 0) begin
            reportFailure("The trace file holds no request lines.");
        end
    endtask

    // Sends one port's lines of a phase, holding each until its accept pulse.
    task automatic drivePort(input int port, input int phase);
        int k;
        @(posedge clk);
        for (k = 0; k < numLines; k++) begin
            if (tracePhase[k] == phase && tracePort[k] == port) begin
                reqValid[port] <= 1'b1;
                reqWrite[port] <= (traceWrite[k] != 0);
                reqAddr[port] <= neighborPkg::addrT'(traceAddr[k]);
                reqData[port] <= neighborPkg::dataT'(traceData[k]);
                if (traceWrite[k] == 0) begin
                    pendPort.push_back(port);
                    pendLine.push_back(k);
                end
                do @(posedge clk); while (!reqAccept[port]);
            end
        end
        reqValid[port] <= 1'b0;
    endtask

    // Matches a response with the oldest pending read of its tag.
    task automatic checkResponse(input int bank);
        int tag;
        int found;
        int k;
        int line;
        string name;
        tag = rspTag[bank];
        found = -1;
        for (k = 0; k < pendPort.size(); k++) begin
            if (found < 0 && pendPort[k] == tag) found = k;
        end
        if (found < 0) begin
            reportFailure($sformatf("Bank %0d returned a response for port %0d with no read pending.",
                                    bank, tag));
        end else begin
            line = pendLine[found];
            pendPort.delete(found);
            pendLine.delete(found);
            name = $sformatf("phase %0d port %0d read %02h", tracePhase[line], tag,
                             traceAddr[line]);
            checkValue({name, " data"}, traceExp[line], rspData[bank]);
            checkValue({name, " bank"}, traceAddr[line] >> neighborPkg::WordAddrWidth, bank);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < neighborPkg::NumBanks; b++) begin
                if (rspValid[b]) checkResponse(b);
            end
        end
    end

    always @(posedge clk) begin
        if (assertionFailed()) begin
            reportFailure("A bound assertion on the dispatcher or the arbiter failed.");
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycleLimit != 0 && cycles >= cycleLimit) begin
            reportFailure($sformatf("Timeout after %0d cycles with %0d reads still unanswered.",
                                    cycles, pendLine.size()));
        end
    end

    initial begin
        reset = 1'b0;
        reqValid = '0;
        reqWrite = '0;
        reqAddr = '0;
        reqData = '0;
        loadTrace();
        cycleLimit = 40 * numLines + 200;
        repeat (10) @(posedge clk);
        reset <= 1'b1;
        for (int phase = 1; phase <= maxPhase; phase++) begin
            fork
                drivePort(0, phase);
                drivePort(1, phase);
                drivePort(2, phase);
                drivePort(3, phase);
            join
            while (pendLine.size() != 0) @(posedge clk);  // Phase ends once all reads returned.
            repeat (8) @(posedge clk);
        end
        if (assertionFailed()) begin
            reportFailure("A bound assertion on the dispatcher or the arbiter failed.");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// File: sim.f
src/neighborPkg.sv
src/requestArbiter.sv
src/requestFifo.sv
src/neighborMemCntl.sv
src/neighborBankCntl.sv
src/neighborMemTop.sv
bench/neighborMem_props.sv
bench/neighborMemTb.sv

// File: bench/neighborTrace.txt
# phase port write addr data expected
# write is 1 for a write and 0 for a read; addr, data and expected are hex
1 0 1 00 005A 0000
1 0 1 10 105A 0000
1 0 1 20 205A 0000
1 0 1 30 305A 0000
1 1 1 01 015A 0000
1 1 1 11 115A 0000
1 1 1 21 215A 0000
1 1 1 31 315A 0000
1 2 1 02 025A 0000
1 2 1 12 125A 0000
1 2 1 22 225A 0000
1 2 1 32 325A 0000
1 3 1 03 035A 0000
1 3 1 13 135A 0000
1 3 1 23 235A 0000
1 3 1 33 335A 0000
2 0 0 00 0000 005A
2 0 0 10 0000 105A
2 0 0 20 0000 205A
2 0 0 30 0000 305A
2 1 0 11 0000 115A
2 1 0 21 0000 215A
2 1 0 31 0000 315A
2 1 0 01 0000 015A
2 2 0 22 0000 225A
2 2 0 32 0000 325A
2 2 0 02 0000 025A
2 2 0 12 0000 125A
2 3 0 33 0000 335A
2 3 0 03 0000 035A
2 3 0 13 0000 135A
2 3 0 23 0000 235A
3 0 0 20 0000 205A
3 0 0 21 0000 215A
3 0 0 22 0000 225A
3 0 0 23 0000 235A
